// ==== src/cacc_pkg.sv ====
package cacc_pkg;

  ////////////////////////////////////////
  // Column geometry and widths
  ////////////////////////////////////////

  localparam int CACC_Y_DIM = 4;
  localparam int Y_CORD_W   = 2;
  localparam int TAG_W      = 4;
  localparam int OPND_W     = 16; // Two operands share one payload.
  localparam int DATA_W     = 32;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic
  {
    KIND_REQ  = 1'b0,
    KIND_RESP = 1'b1
  } cacc_kind_e;

  // Codes 5 to 7 are illegal.
  typedef enum logic [2:0]
  {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_XOR = 3'd2,
    OP_MAC = 3'd3,
    OP_CLR = 3'd4
  } cacc_op_e;

  ////////////////////////////////////////
  // Network and pipeline payloads
  ////////////////////////////////////////

  // Raw opcode bits, so that illegal codes can travel to the tile.
  typedef struct packed
  {
    cacc_kind_e          kind;
    logic [Y_CORD_W-1:0] dest_y;
    logic [Y_CORD_W-1:0] src_y;
    logic [TAG_W-1:0]    tag;
    logic [2:0]          op;
    logic                err;
    logic [DATA_W-1:0]   payload; // Request: {a, b}. Response: result.
  } cacc_flit_s;

  // The ready_and_rev field runs against v and data.
  typedef struct packed
  {
    logic       v;
    cacc_flit_s data;
    logic       ready_and_rev;
  } cacc_link_s;

  typedef struct packed
  {
    logic [Y_CORD_W-1:0] src_y;
    logic [TAG_W-1:0]    tag;
    cacc_op_e            op;
    logic [OPND_W-1:0]   a;
    logic [OPND_W-1:0]   b;
    logic                illegal;
  } cacc_dec_s;

  typedef struct packed
  {
    logic [Y_CORD_W-1:0] src_y;
    logic [TAG_W-1:0]    tag;
    logic                err;
    logic [DATA_W-1:0]   value;
  } cacc_res_s;

endpackage

// ==== src/cacc_router.sv ====
`timescale 1ns/1ps

module cacc_router
  (input  logic                          core_clk_i
  , input  logic                         arst_n_i
  , input  logic [cacc_pkg::Y_CORD_W-1:0] my_y_i

  , input  cacc_pkg::cacc_link_s         w_link_i
  , input  cacc_pkg::cacc_link_s         n_link_i
  , input  cacc_pkg::cacc_link_s         s_link_i
  , input  cacc_pkg::cacc_link_s         p_link_i

  , output cacc_pkg::cacc_link_s         w_link_o
  , output cacc_pkg::cacc_link_s         n_link_o
  , output cacc_pkg::cacc_link_s         s_link_o
  , output cacc_pkg::cacc_link_s         p_link_o
  );

  // Port order is W, N, S, P on every array below.
  cacc_pkg::cacc_link_s [3:0] in_link;
  cacc_pkg::cacc_link_s [3:0] out_link;

  logic [3:0]                 buf_v;
  cacc_pkg::cacc_flit_s [3:0] buf_flit;
  logic [3:0][1:0]            buf_dir;
  logic [3:0][1:0]            rr_ptr;
  logic [3:0][1:0]            gnt;
  logic [3:0]                 out_v;
  logic [3:0]                 fire;
  logic [3:0]                 deq;
  logic [3:0]                 in_rdy;

  assign in_link = {p_link_i, s_link_i, n_link_i, w_link_i};

  function automatic logic [1:0] route_dir
    (input cacc_pkg::cacc_flit_s      flit
    , input logic [cacc_pkg::Y_CORD_W-1:0] my_y
    );
    logic [1:0] dir;
    if (flit.dest_y == my_y)
      dir = (flit.kind == cacc_pkg::KIND_REQ) ? 2'd3 : 2'd0;
    else if (flit.dest_y < my_y)
      dir = 2'd1;
    else
      dir = 2'd2;
    return dir;
  endfunction

  ////////////////////////////////////////
  // Output arbitration
  ////////////////////////////////////////

  always_comb
  begin
    logic [1:0] idx;
    for (int o = 0; o < 4; o++)
    begin
      out_v[o] = 1'b0;
      gnt[o]   = rr_ptr[o];
      // Walk backwards so the input nearest the pointer wins.
      for (int k = 3; k >= 0; k--)
      begin
        idx = rr_ptr[o] + 2'(k);
        if (buf_v[idx] && (buf_dir[idx] == 2'(o)))
        begin
          out_v[o] = 1'b1;
          gnt[o]   = idx;
        end
      end
      fire[o] = out_v[o] & in_link[o].ready_and_rev; // Downstream ready arrives on the input.
    end
  end

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      deq[i] = 1'b0;
      for (int o = 0; o < 4; o++)
        if (fire[o] && (gnt[o] == 2'(i)))
          deq[i] = 1'b1;
      in_rdy[i] = ~buf_v[i] | deq[i];
    end
  end

  always_comb
  begin
    for (int o = 0; o < 4; o++)
    begin
      out_link[o].v             = out_v[o];
      out_link[o].data          = buf_flit[gnt[o]];
      out_link[o].ready_and_rev = in_rdy[o];
    end
  end

  assign w_link_o = out_link[0];
  assign n_link_o = out_link[1];
  assign s_link_o = out_link[2];
  assign p_link_o = out_link[3];

  ////////////////////////////////////////
  // Input buffers
  ////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      buf_v  <= '0;
      rr_ptr <= '0;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (in_link[i].v && in_rdy[i])
          buf_v[i] <= 1'b1;
        else if (deq[i])
          buf_v[i] <= 1'b0;
      end
      for (int o = 0; o < 4; o++)
        if (fire[o])
          rr_ptr[o] <= gnt[o] + 2'd1; // Winner drops to lowest priority.
        else if (out_v[o])
          rr_ptr[o] <= gnt[o]; // Offered flit keeps the grant until it moves.
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (in_link[i].v && in_rdy[i])
      begin
        buf_flit[i] <= in_link[i].data;
        buf_dir[i]  <= route_dir(in_link[i].data, my_y_i);
      end
    end
  end

  // A flit offered on the west edge stays put until the edge takes it.
  a_w_hold : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    (w_link_o.v && !w_link_i.ready_and_rev) |=> (w_link_o.v && $stable(w_link_o.data)));

endmodule

// ==== src/cacc_decode.sv ====
`timescale 1ns/1ps

module cacc_decode
  (input  logic                  core_clk_i
  , input  logic                 arst_n_i

  , input  cacc_pkg::cacc_link_s req_link_i
  , output cacc_pkg::cacc_link_s req_link_o

  , output logic                 dec_v_o
  , output cacc_pkg::cacc_dec_s  dec_o
  , input  logic                 dec_ready_i
  );

  logic                dec_v_r;
  cacc_pkg::cacc_dec_s dec_r;
  logic                req_rdy;
  logic                req_fire;

  assign req_rdy  = ~dec_v_r | dec_ready_i;
  assign req_fire = req_link_i.v & req_rdy;

  // Decode only sinks requests on this link.
  assign req_link_o.v             = 1'b0;
  assign req_link_o.data          = '0;
  assign req_link_o.ready_and_rev = req_rdy;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dec_v_r <= 1'b0;
    else if (req_fire)
      dec_v_r <= 1'b1;
    else if (dec_ready_i)
      dec_v_r <= 1'b0;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (req_fire)
    begin
      dec_r.src_y   <= req_link_i.data.src_y;
      dec_r.tag     <= req_link_i.data.tag;
      dec_r.op      <= cacc_pkg::cacc_op_e'(req_link_i.data.op);
      dec_r.a       <= req_link_i.data.payload[cacc_pkg::DATA_W-1 -: cacc_pkg::OPND_W];
      dec_r.b       <= req_link_i.data.payload[cacc_pkg::OPND_W-1:0];
      dec_r.illegal <= (req_link_i.data.op > 3'(cacc_pkg::OP_CLR)); // Codes 5..7.
    end
  end

  assign dec_v_o = dec_v_r;
  assign dec_o   = dec_r;

  // Router only hands requests to the P port.
  a_req_only : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    req_fire |-> (req_link_i.data.kind == cacc_pkg::KIND_REQ));

endmodule

// ==== src/cacc_execute.sv ====
`timescale 1ns/1ps

module cacc_execute
  (input  logic                 core_clk_i
  , input  logic                arst_n_i

  , input  logic                dec_v_i
  , input  cacc_pkg::cacc_dec_s dec_i
  , output logic                dec_ready_o

  , output logic                res_v_o
  , output cacc_pkg::cacc_res_s res_o
  , input  logic                res_ready_i
  );

  logic                              s1_v;
  logic [cacc_pkg::Y_CORD_W-1:0]     s1_src_y;
  logic [cacc_pkg::TAG_W-1:0]        s1_tag;
  cacc_pkg::cacc_op_e                s1_op;
  logic                              s1_ill;
  logic [cacc_pkg::DATA_W-1:0]       s1_val;

  logic                              s2_v;
  cacc_pkg::cacc_res_s               s2_res;

  logic [cacc_pkg::DATA_W-1:0]       acc_q;
  logic [cacc_pkg::DATA_W-1:0]       acc_nxt;
  logic [cacc_pkg::DATA_W-1:0]       s2_val;
  logic [cacc_pkg::DATA_W-1:0]       alu_val;
  logic [cacc_pkg::DATA_W-1:0]       a_ext;
  logic [cacc_pkg::DATA_W-1:0]       b_ext;

  logic                              s2_rdy;
  logic                              s1_adv;
  logic                              dec_fire;

  assign s2_rdy      = ~s2_v | res_ready_i;
  assign s1_adv      = s1_v & s2_rdy;
  assign dec_ready_o = ~s1_v | s2_rdy;
  assign dec_fire    = dec_v_i & dec_ready_o;

  ////////////////////////////////////////
  // Stage one, arithmetic
  ////////////////////////////////////////

  assign a_ext = cacc_pkg::DATA_W'(dec_i.a);
  assign b_ext = cacc_pkg::DATA_W'(dec_i.b);

  always_comb
  begin
    case (dec_i.op)
      cacc_pkg::OP_ADD: alu_val = a_ext + b_ext;
      cacc_pkg::OP_SUB: alu_val = a_ext - b_ext; // Wraps.
      cacc_pkg::OP_XOR: alu_val = a_ext ^ b_ext;
      cacc_pkg::OP_MAC: alu_val = a_ext * b_ext;
      default:          alu_val = '0;
    endcase
  end

  ////////////////////////////////////////
  // Stage two, accumulator
  ////////////////////////////////////////

  always_comb
  begin
    acc_nxt = acc_q;
    s2_val  = s1_val;
    if (s1_ill)
      s2_val = '0;
    else
    begin
      case (s1_op)
        cacc_pkg::OP_MAC:
        begin
          acc_nxt = acc_q + s1_val;
          s2_val  = acc_nxt;
        end
        cacc_pkg::OP_CLR:
        begin
          acc_nxt = '0;
          s2_val  = '0;
        end
        default:
          s2_val = s1_val;
      endcase
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      s1_v  <= 1'b0;
      s2_v  <= 1'b0;
      acc_q <= '0;
    end
    else
    begin
      if (dec_fire)
        s1_v <= 1'b1;
      else if (s1_adv)
        s1_v <= 1'b0;

      if (s1_adv)
      begin
        s2_v  <= 1'b1;
        acc_q <= acc_nxt;
      end
      else if (res_ready_i)
        s2_v <= 1'b0;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (dec_fire)
    begin
      s1_src_y <= dec_i.src_y;
      s1_tag   <= dec_i.tag;
      s1_op    <= dec_i.op;
      s1_ill   <= dec_i.illegal;
      s1_val   <= alu_val;
    end
    if (s1_adv)
    begin
      s2_res.src_y <= s1_src_y;
      s2_res.tag   <= s1_tag;
      s2_res.err   <= s1_ill;
      s2_res.value <= s2_val;
    end
  end

  assign res_v_o = s2_v;
  assign res_o   = s2_res;

endmodule

// ==== src/cacc_result.sv ====
`timescale 1ns/1ps

module cacc_result
  (input  logic                           core_clk_i
  , input  logic                          arst_n_i
  , input  logic [cacc_pkg::Y_CORD_W-1:0] my_y_i

  , input  logic                          res_v_i
  , input  cacc_pkg::cacc_res_s           res_i
  , output logic                          res_ready_o

  , input  cacc_pkg::cacc_link_s          resp_link_i
  , output cacc_pkg::cacc_link_s          resp_link_o
  );

  cacc_pkg::cacc_flit_s [1:0] q_flit;
  cacc_pkg::cacc_flit_s       new_flit;
  logic                       wr_ptr;
  logic                       rd_ptr;
  logic [1:0]                 count;
  logic                       push;
  logic                       pop;

  // Ready depends on the fill level alone.
  assign res_ready_o = (count != 2'd2);
  assign push        = res_v_i & res_ready_o;
  assign pop         = resp_link_o.v & resp_link_i.ready_and_rev;

  always_comb
  begin
    new_flit         = '0;
    new_flit.kind    = cacc_pkg::KIND_RESP;
    new_flit.dest_y  = res_i.src_y; // Back to the requester.
    new_flit.src_y   = my_y_i;
    new_flit.tag     = res_i.tag;
    new_flit.err     = res_i.err;
    new_flit.payload = res_i.value;
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (push)
      q_flit[wr_ptr] <= new_flit;
  end

  assign resp_link_o.v             = (count != 2'd0);
  assign resp_link_o.data          = q_flit[rd_ptr];
  assign resp_link_o.ready_and_rev = 1'b0; // Source only.

  // A result refused while the queue is full is held upstream and not lost.
  a_no_overflow : assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    (res_v_i && !res_ready_o) |=> (res_v_i && $stable(res_i)));

endmodule

// ==== src/cacc_tile_node.sv ====
`timescale 1ns/1ps

module cacc_tile_node
  (input  logic                           core_clk_i
  , input  logic                          arst_n_i
  , input  logic [cacc_pkg::Y_CORD_W-1:0] my_y_i

  , input  cacc_pkg::cacc_link_s          w_link_i
  , input  cacc_pkg::cacc_link_s          n_link_i
  , input  cacc_pkg::cacc_link_s          s_link_i

  , output cacc_pkg::cacc_link_s          w_link_o
  , output cacc_pkg::cacc_link_s          n_link_o
  , output cacc_pkg::cacc_link_s          s_link_o
  );

  cacc_pkg::cacc_link_s p_link_li;
  cacc_pkg::cacc_link_s p_link_lo;
  cacc_pkg::cacc_link_s dec_link_lo;
  cacc_pkg::cacc_link_s resp_link_lo;

  logic                 dec_v;
  cacc_pkg::cacc_dec_s  dec;
  logic                 dec_ready;
  logic                 res_v;
  cacc_pkg::cacc_res_s  res;
  logic                 res_ready;

  // Responses go in on P while decode returns its ready.
  assign p_link_li.v             = resp_link_lo.v;
  assign p_link_li.data          = resp_link_lo.data;
  assign p_link_li.ready_and_rev = dec_link_lo.ready_and_rev;

  cacc_router router
    (.core_clk_i(core_clk_i)
    ,.arst_n_i(arst_n_i)
    ,.my_y_i(my_y_i)
    ,.w_link_i(w_link_i)
    ,.n_link_i(n_link_i)
    ,.s_link_i(s_link_i)
    ,.p_link_i(p_link_li)
    ,.w_link_o(w_link_o)
    ,.n_link_o(n_link_o)
    ,.s_link_o(s_link_o)
    ,.p_link_o(p_link_lo)
    );

  cacc_decode decode
    (.core_clk_i(core_clk_i)
    ,.arst_n_i(arst_n_i)
    ,.req_link_i(p_link_lo)
    ,.req_link_o(dec_link_lo)
    ,.dec_v_o(dec_v)
    ,.dec_o(dec)
    ,.dec_ready_i(dec_ready)
    );

  cacc_execute execute
    (.core_clk_i(core_clk_i)
    ,.arst_n_i(arst_n_i)
    ,.dec_v_i(dec_v)
    ,.dec_i(dec)
    ,.dec_ready_o(dec_ready)
    ,.res_v_o(res_v)
    ,.res_o(res)
    ,.res_ready_i(res_ready)
    );

  cacc_result result
    (.core_clk_i(core_clk_i)
    ,.arst_n_i(arst_n_i)
    ,.my_y_i(my_y_i)
    ,.res_v_i(res_v)
    ,.res_i(res)
    ,.res_ready_o(res_ready)
    ,.resp_link_i(p_link_lo)
    ,.resp_link_o(resp_link_lo)
    );

endmodule

// ==== src/cacc_complex.sv ====
`timescale 1ns/1ps

module cacc_complex
  (input  logic                                            core_clk_i
  , input  logic                                           arst_n_i

  , input  cacc_pkg::cacc_link_s [cacc_pkg::CACC_Y_DIM-1:0] link_i
  , output cacc_pkg::cacc_link_s [cacc_pkg::CACC_Y_DIM-1:0] link_o
  );

  cacc_pkg::cacc_link_s [cacc_pkg::CACC_Y_DIM-1:0] n_link_li, n_link_lo;
  cacc_pkg::cacc_link_s [cacc_pkg::CACC_Y_DIM-1:0] s_link_li, s_link_lo;

  for (genvar j = 0; j < cacc_pkg::CACC_Y_DIM; j++)
  begin : y
    cacc_tile_node node
      (.core_clk_i(core_clk_i)
      ,.arst_n_i(arst_n_i)
      ,.my_y_i(cacc_pkg::Y_CORD_W'(j))
      ,.w_link_i(link_i[j])
      ,.n_link_i(n_link_li[j])
      ,.s_link_i(s_link_li[j])
      ,.w_link_o(link_o[j])
      ,.n_link_o(n_link_lo[j])
      ,.s_link_o(s_link_lo[j])
      );

    // Top and bottom edges of the column are tied off.
    if (j == 0)
    begin : top_edge
      assign n_link_li[j] = '0;
    end
    else
    begin : north_stitch
      assign n_link_li[j] = s_link_lo[j-1];
    end

    if (j == cacc_pkg::CACC_Y_DIM-1)
    begin : bottom_edge
      assign s_link_li[j] = '0;
    end
    else
    begin : south_stitch
      assign s_link_li[j] = n_link_lo[j+1];
    end
  end

endmodule

// ==== sim/tb_cacc_complex.sv ====
`timescale 1ns/1ps

module tb_cacc_complex;

  localparam int ROWS            = cacc_pkg::CACC_Y_DIM;
  localparam int LOCAL_REQS      = ROWS * 3 * 2;
  localparam int ROUTE_REQS      = ROWS * ROWS;
  localparam int ACC_REQS        = 9;
  localparam int ILL_REQS        = 5;
  localparam int BP_PER_ROW      = 40;
  localparam int TOTAL_REQS      = LOCAL_REQS + ROUTE_REQS + ACC_REQS + ILL_REQS
                                   + ROWS * BP_PER_ROW;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 200 + 1000;
  localparam int MAX_OUTSTANDING = 3; // Per-row limit that keeps the shared network out of deadlock.

  typedef struct packed
  {
    logic [cacc_pkg::TAG_W-1:0]  tag;
    logic                        err;
    logic [cacc_pkg::DATA_W-1:0] value;
  } resp_exp_s;

  logic                            core_clk;
  logic                            arst_n;
  cacc_pkg::cacc_link_s [ROWS-1:0] link_i;
  cacc_pkg::cacc_link_s [ROWS-1:0] link_o;

  integer                      seed;
  string                       test_name;
  logic                        bp_en;
  int                          issued;
  int                          received;
  int                          launched  [ROWS];
  int                          recv_cnt  [ROWS];
  logic [cacc_pkg::TAG_W-1:0]  next_tag  [ROWS];
  logic [cacc_pkg::DATA_W-1:0] model_acc [ROWS];
  resp_exp_s                   exp_q     [ROWS*ROWS][$]; // Index is src * ROWS + dest.
  cacc_pkg::cacc_flit_s        pend_q    [ROWS][$];

  cacc_complex dut0
    (.core_clk_i(core_clk)
    ,.arst_n_i(arst_n)
    ,.link_i(link_i)
    ,.link_o(link_o)
    );

  initial
  begin
    core_clk = 1'b0;
    forever #4 core_clk = ~core_clk;
  end

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  function automatic logic [cacc_pkg::DATA_W-1:0] ref_exec
    (input logic [2:0]                   op
    , input logic [cacc_pkg::OPND_W-1:0] a
    , input logic [cacc_pkg::OPND_W-1:0] b
    , inout logic [cacc_pkg::DATA_W-1:0] acc
    , output logic                       err
    );
    logic [cacc_pkg::DATA_W-1:0] wa;
    logic [cacc_pkg::DATA_W-1:0] wb;
    logic [cacc_pkg::DATA_W-1:0] result;
    wa  = {{(cacc_pkg::DATA_W-cacc_pkg::OPND_W){1'b0}}, a};
    wb  = {{(cacc_pkg::DATA_W-cacc_pkg::OPND_W){1'b0}}, b};
    err = 1'b0;
    case (op)
      3'd0: result = wa + wb;
      3'd1: result = wa - wb;
      3'd2: result = wa ^ wb;
      3'd3:
      begin
        acc    = acc + wa * wb;
        result = acc;
      end
      3'd4:
      begin
        acc    = '0;
        result = '0;
      end
      default:
      begin
        err    = 1'b1; // Accumulator untouched.
        result = '0;
      end
    endcase
    return result;
  endfunction

  function automatic logic [cacc_pkg::OPND_W-1:0] rand_opnd();
    return cacc_pkg::OPND_W'($random(seed));
  endfunction

  task automatic abort_run(input string msg);
    $display("ERROR %s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value
    (input string       name
    , input logic [31:0] expected
    , input logic [31:0] actual
    );
    if (actual !== expected)
    begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic issue_req
    (input int                           src
    , input int                          dest
    , input logic [2:0]                  op
    , input logic [cacc_pkg::OPND_W-1:0] a
    , input logic [cacc_pkg::OPND_W-1:0] b
    );
    cacc_pkg::cacc_flit_s flit;
    resp_exp_s            exp_r;
    logic                 err_bit;
    flit          = '0;
    flit.kind     = cacc_pkg::KIND_REQ;
    flit.dest_y   = cacc_pkg::Y_CORD_W'(dest);
    flit.src_y    = cacc_pkg::Y_CORD_W'(src);
    flit.tag      = next_tag[src];
    flit.op       = op;
    flit.payload  = {a, b};
    exp_r.value   = ref_exec(op, a, b, model_acc[dest], err_bit);
    exp_r.err     = err_bit;
    exp_r.tag     = next_tag[src];
    next_tag[src] = next_tag[src] + 1'b1;
    exp_q[src*ROWS + dest].push_back(exp_r);
    pend_q[src].push_back(flit);
    issued++;
  endtask

  task automatic check_resp(input int row, input cacc_pkg::cacc_flit_s flit);
    int        qi;
    resp_exp_s exp_r;
    qi = row * ROWS + int'(flit.src_y);
    if (exp_q[qi].size() == 0)
      abort_run($sformatf("response on row %0d from tile %0d with tag %0h was not expected",
                          row, flit.src_y, flit.tag));
    else
    begin
      exp_r = exp_q[qi].pop_front();
      check_value({test_name, " kind"}, 32'(cacc_pkg::KIND_RESP), 32'(flit.kind));
      check_value({test_name, " dest_y"}, 32'(row), 32'(flit.dest_y));
      check_value({test_name, " tag"}, 32'(exp_r.tag), 32'(flit.tag));
      check_value({test_name, " err"}, 32'(exp_r.err), 32'(flit.err));
      check_value({test_name, " value"}, exp_r.value, flit.payload);
      recv_cnt[row]++;
      received++;
    end
  endtask

  task automatic wait_drain;
    while (received != issued)
      @(negedge core_clk);
  endtask

  ////////////////////////////////////////
  // Link driver, monitor, watchdog
  ////////////////////////////////////////

  initial
  begin : drive_links
    logic took [ROWS];
    for (int r = 0; r < ROWS; r++)
    begin
      link_i[r]               = '0;
      link_i[r].ready_and_rev = 1'b1;
      launched[r]             = 0;
    end
    wait (arst_n === 1'b1);
    forever
    begin
      @(negedge core_clk);
      for (int r = 0; r < ROWS; r++)
        took[r] = link_i[r].v && link_o[r].ready_and_rev; // Transfer on the coming edge.
      @(posedge core_clk);
      for (int r = 0; r < ROWS; r++)
      begin
        if (took[r] || !link_i[r].v)
        begin
          if (pend_q[r].size() != 0 && (launched[r] - recv_cnt[r]) < MAX_OUTSTANDING)
          begin
            link_i[r].v    <= 1'b1;
            link_i[r].data <= pend_q[r].pop_front();
            launched[r]++;
          end
          else
          begin
            link_i[r].v    <= 1'b0;
            link_i[r].data <= '0;
          end
        end
        link_i[r].ready_and_rev <= bp_en ? (($random(seed) % 4) != 0) : 1'b1;
      end
    end
  end

  initial
  begin : monitor
    received = 0;
    for (int r = 0; r < ROWS; r++)
      recv_cnt[r] = 0;
    forever
    begin
      @(negedge core_clk);
      if (arst_n)
        for (int r = 0; r < ROWS; r++)
          if (link_o[r].v && link_i[r].ready_and_rev)
            check_resp(r, link_o[r].data);
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge core_clk);
    abort_run($sformatf("timeout after %0d cycles, %0d of %0d responses are missing",
                        WATCHDOG_CYCLES, issued - received, issued));
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin : run_tests
    int dest;
    int code;
    seed      = 85819;
    bp_en     = 1'b0;
    issued    = 0;
    test_name = "reset";
    for (int r = 0; r < ROWS; r++)
    begin
      next_tag[r]  = '0;
      model_acc[r] = '0;
    end
    arst_n = 1'b0;
    repeat (2) @(posedge core_clk);
    arst_n <= 1'b1;

    // Idle column offers nothing and accepts on every row.
    @(negedge core_clk);
    for (int r = 0; r < ROWS; r++)
    begin
      check_value({test_name, " v"}, 32'd0, 32'(link_o[r].v));
      check_value({test_name, " ready"}, 32'd1, 32'(link_o[r].ready_and_rev));
    end

    test_name = "local_ops";
    for (int r = 0; r < ROWS; r++)
    begin
      issue_req(r, r, cacc_pkg::OP_ADD, 16'hffff, 16'hffff); // Carries past 16 bits.
      issue_req(r, r, cacc_pkg::OP_SUB, 16'h0000, 16'h0001); // Wraps to all ones.
      issue_req(r, r, cacc_pkg::OP_XOR, 16'ha5a5, 16'h0ff0);
      issue_req(r, r, cacc_pkg::OP_ADD, rand_opnd(), rand_opnd());
      issue_req(r, r, cacc_pkg::OP_SUB, rand_opnd(), rand_opnd());
      issue_req(r, r, cacc_pkg::OP_XOR, rand_opnd(), rand_opnd());
    end
    wait_drain();

    test_name = "remote_routing";
    for (int s = 0; s < ROWS; s++)
      for (int d = 0; d < ROWS; d++)
        issue_req(s, d, cacc_pkg::OP_ADD, rand_opnd(), rand_opnd());
    wait_drain();

    test_name = "accumulate";
    for (int k = 0; k < 5; k++)
      issue_req(1, 2, cacc_pkg::OP_MAC, rand_opnd(), rand_opnd());
    issue_req(1, 2, cacc_pkg::OP_CLR, rand_opnd(), rand_opnd());
    for (int k = 0; k < 3; k++)
      issue_req(1, 2, cacc_pkg::OP_MAC, rand_opnd(), rand_opnd());
    wait_drain();

    test_name = "illegal_ops";
    issue_req(0, 3, cacc_pkg::OP_MAC, 16'h1234, 16'h0010);
    for (int c = 5; c < 8; c++)
      issue_req(0, 3, 3'(c), rand_opnd(), rand_opnd());
    issue_req(0, 3, cacc_pkg::OP_MAC, 16'h0003, 16'h0004);
    wait_drain();

    // Accumulator ops stay out because their order across rows is not fixed.
    test_name = "back_pressure";
    bp_en     = 1'b1;
    for (int n = 0; n < BP_PER_ROW; n++)
    begin
      for (int r = 0; r < ROWS; r++)
      begin
        dest = $unsigned($random(seed)) % ROWS;
        code = $unsigned($random(seed)) % 6;
        issue_req(r, dest, (code < 3) ? 3'(code) : 3'(code + 2), rand_opnd(), rand_opnd());
      end
    end
    wait_drain();
    bp_en = 1'b0;

    if (received == issued && issued == TOTAL_REQS)
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
    else
      abort_run($sformatf("%0d requests issued but %0d responses received, %0d planned",
                          issued, received, TOTAL_REQS));
  end

endmodule

// ==== cacc_column.f ====
src/cacc_pkg.sv
src/cacc_router.sv
src/cacc_decode.sv
src/cacc_execute.sv
src/cacc_result.sv
src/cacc_tile_node.sv
src/cacc_complex.sv
sim/tb_cacc_complex.sv

// ==== Bender.yml ====
package:
  name: cacc_column

sources:
  # Package first, then the tile blocks, then the column top.
  - src/cacc_pkg.sv
  - src/cacc_router.sv
  - src/cacc_decode.sv
  - src/cacc_execute.sv
  - src/cacc_result.sv
  - src/cacc_tile_node.sv
  - src/cacc_complex.sv

  - target: any(simulation, test)
    files:
      - sim/tb_cacc_complex.sv
